/* common/obj_pkg.sv */
// object engine shared definitions
// table geometry and end-of-list marker
// copier and scanner FSM state enums
// 16-bit video data word type

package obj_pkg;

    // words in one half of the double-buffered table
    localparam int obj_table_words = 1024;

    // x, y, code, attribute
    localparam int obj_words_per_entry = 4;

    // hard limit on objects per frame
    localparam int obj_max_entries = 256;

    // upper byte of the attribute word that ends the list
    localparam logic [7:0] obj_end_attr = 8'hff;

    // one video RAM or table word
    typedef logic [15:0] obj_word_t;

    // DMA copier states
    typedef enum logic {
        DMA_IDLE,
        DMA_COPY
    } obj_dma_state_t;

    // object list scanner states
    typedef enum logic [1:0] {
        SCAN_IDLE,
        // address phase then data phase for each word
        SCAN_READ,
        // one cycle with the descriptor strobe high
        SCAN_EMIT
    } obj_scan_state_t;

endpackage

/* common/obj_vram_if.sv */
// video RAM read channel
// chip select level, word address, read data and acknowledge strobe
// copier and memory side modports

`timescale 1ns/10ps

interface obj_vram_if import obj_pkg::*; ();

    // held high for the whole table copy
    logic        cs;
    // word address, bit 0 of the byte address does not exist
    logic [23:1] addr;
    // read data for addr, valid while ok is high
    obj_word_t   data;
    // acknowledge, may stay low for any number of cycles
    logic        ok;

    // DMA master side
    modport copier (
        output cs,
        output addr,
        input  data,
        input  ok
    );

    // RAM or SDRAM controller side
    modport memory (
        input  cs,
        input  addr,
        output data,
        output ok
    );

endinterface

/* obj/obj_table.sv */
// object table copier
// 2048-word double-buffered table, one half written and one half read
// half flip at the falling edge of vertical blank
// DMA copy FSM that pulls 1024 words from video RAM

`timescale 1ns/10ps

module obj_table import obj_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        vb,
    input  logic [15:0] vram_base,
    obj_vram_if.copier  vram,
    input  logic [9:0]  table_addr,
    output logic [15:0] table_data
);

    // index of the final word of a copy
    localparam logic [9:0] last_idx = 10'(obj_table_words - 1);

    // both halves in one array, top address bit selects the half
    obj_word_t      buffer [0:2*obj_table_words-1];

    obj_dma_state_t state;
    logic           last_vb;
    logic           frame_start;
    // half seen by the scanner, the copier writes the other one
    logic           rd_half;
    // blocks ok for one cycle after entry and after every accept
    logic           wait_cycle;
    logic           accept;

    // registered write port
    logic           wr_en;
    logic [9:0]     wr_addr;
    obj_word_t      wr_data;

    // end of blanking
    assign frame_start = last_vb && !vb;

    // a word is taken only outside the wait cycle
    assign accept = (state == DMA_COPY) && vram.cs && vram.ok && !wait_cycle;

    // write side of the buffer
    always_ff @(posedge clk) begin
        if (wr_en) begin
            buffer[{~rd_half, wr_addr}] <= wr_data;
        end
    end

    // read side, data one cycle after the address
    always_ff @(posedge clk) begin
        table_data <= buffer[{rd_half, table_addr}];
    end

    // word and index captured on every cycle
    // only the accept cycle is followed by a write
    always_ff @(posedge clk) begin
        wr_addr <= vram.addr[10:1];
        wr_data <= vram.data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= accept;
        end
    end

    // copy FSM
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= DMA_IDLE;
            last_vb    <= 1'b0;
            rd_half    <= 1'b0;
            wait_cycle <= 1'b1;
            vram.cs    <= 1'b0;
            vram.addr  <= '0;
        end else begin
            last_vb <= vb;
            case (state)
                DMA_IDLE: begin
                    wait_cycle <= 1'b1;
                    // vb is only watched here, a fall during a copy is lost
                    if (frame_start) begin
                        // scanner gets last frame's table right away
                        rd_half   <= ~rd_half;
                        // base latched here, later changes wait for next frame
                        vram.addr <= {vram_base[15:3], 10'd0};
                        vram.cs   <= 1'b1;
                        state     <= DMA_COPY;
                    end
                end
                DMA_COPY: begin
                    wait_cycle <= 1'b0;
                    if (accept) begin
                        wait_cycle      <= 1'b1;
                        // only the table index moves, base bits stay
                        vram.addr[10:1] <= vram.addr[10:1] + 10'd1;
                        // 1024th word taken, release the bus
                        if (vram.addr[10:1] == last_idx) begin
                            vram.cs <= 1'b0;
                            state   <= DMA_IDLE;
                        end
                    end
                end
                default: begin
                    vram.cs <= 1'b0;
                    state   <= DMA_IDLE;
                end
            endcase
        end
    end

endmodule

/* obj/obj_scan.sv */
// object list scanner
// walks the readable table half four words per entry
// one descriptor strobe per object
// stops at the end marker or after 256 objects, then pulses scan_done

`timescale 1ns/10ps

module obj_scan import obj_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        vb,
    output logic [9:0]  table_addr,
    input  logic [15:0] table_data,
    output logic        obj_valid,
    output logic [15:0] obj_x,
    output logic [15:0] obj_y,
    output logic [15:0] obj_code,
    output logic [15:0] obj_attr,
    output logic        scan_done
);

    obj_scan_state_t state;
    logic            last_vb;
    logic            frame_start;
    // 0 while the address is presented, 1 while table_data is valid
    logic            phase;
    // objects emitted so far this frame
    logic [7:0]      entry_cnt;
    // x, y and code held until the attribute arrives
    obj_word_t       ent [0:2];
    logic            last_word;
    logic            end_mark;
    logic            last_entry;

    assign frame_start = last_vb && !vb;

    // word position inside the entry comes from the low address bits
    assign last_word = table_addr[1:0] == 2'(obj_words_per_entry - 1);

    // only meaningful on the attribute word
    assign end_mark = table_data[15:8] == obj_end_attr;

    assign last_entry = entry_cnt == 8'(obj_max_entries - 1);

    // payload capture
    always_ff @(posedge clk) begin
        if (state == SCAN_READ && phase) begin
            if (last_word) begin
                // marker entry is never emitted, keep the old descriptor
                if (!end_mark) begin
                    obj_x    <= ent[0];
                    obj_y    <= ent[1];
                    obj_code <= ent[2];
                    obj_attr <= table_data;
                end
            end else begin
                ent[table_addr[1:0]] <= table_data;
            end
        end
    end

    // scan FSM
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= SCAN_IDLE;
            last_vb    <= 1'b0;
            phase      <= 1'b0;
            table_addr <= '0;
            entry_cnt  <= '0;
            obj_valid  <= 1'b0;
            scan_done  <= 1'b0;
        end else begin
            last_vb   <= vb;
            // both strobes are single cycle
            obj_valid <= 1'b0;
            scan_done <= 1'b0;
            case (state)
                SCAN_IDLE: begin
                    // same edge as the table half flip
                    if (frame_start) begin
                        table_addr <= '0;
                        phase      <= 1'b0;
                        entry_cnt  <= '0;
                        state      <= SCAN_READ;
                    end
                end
                SCAN_READ: begin
                    // two cycles per word
                    phase <= ~phase;
                    if (phase) begin
                        table_addr <= table_addr + 10'd1;
                        if (last_word) begin
                            if (end_mark) begin
                                scan_done <= 1'b1;
                                state     <= SCAN_IDLE;
                            end else begin
                                obj_valid <= 1'b1;
                                state     <= SCAN_EMIT;
                            end
                        end
                    end
                end
                SCAN_EMIT: begin
                    // descriptor strobe is high in this cycle
                    entry_cnt <= entry_cnt + 8'd1;
                    if (last_entry) begin
                        // full table without a marker
                        scan_done <= 1'b1;
                        state     <= SCAN_IDLE;
                    end else begin
                        state <= SCAN_READ;
                    end
                end
                default: begin
                    state <= SCAN_IDLE;
                end
            endcase
        end
    end

endmodule

/* rtl/obj_engine_top.sv */
// object engine top level
// table copier and list scanner
// video RAM read channel brought out as plain ports

`timescale 1ns/10ps

module obj_engine_top import obj_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    // vertical blank, frame starts on its falling edge
    input  logic        vb,
    // object table location in video RAM
    input  logic [15:0] vram_base,
    // video RAM read port
    output logic        vram_cs,
    output logic [23:1] vram_addr,
    input  obj_word_t   vram_data,
    input  logic        vram_ok,
    // object descriptors to the renderer
    output logic        obj_valid,
    output obj_word_t   obj_x,
    output obj_word_t   obj_y,
    output obj_word_t   obj_code,
    output obj_word_t   obj_attr,
    output logic        scan_done
);

    // copier to memory channel
    obj_vram_if vram_bus ();

    // scanner to table read port
    logic [9:0] table_addr;
    obj_word_t  table_data;

    // memory side of the channel mapped to pins
    assign vram_cs       = vram_bus.cs;
    assign vram_addr     = vram_bus.addr;
    assign vram_bus.data = vram_data;
    assign vram_bus.ok   = vram_ok;

    // DMA into the write half, flips halves per frame
    obj_table table0 (
        .clk        (clk),
        .rst        (rst),
        .vb         (vb),
        .vram_base  (vram_base),
        .vram       (vram_bus.copier),
        .table_addr (table_addr),
        .table_data (table_data)
    );

    // walks the read half holding the previous frame's table
    obj_scan scan0 (
        .clk        (clk),
        .rst        (rst),
        .vb         (vb),
        .table_addr (table_addr),
        .table_data (table_data),
        .obj_valid  (obj_valid),
        .obj_x      (obj_x),
        .obj_y      (obj_y),
        .obj_code   (obj_code),
        .obj_attr   (obj_attr),
        .scan_done  (scan_done)
    );

endmodule

/* testbench/obj_engine_assert.sv */
// bound checks on the video RAM channel and the descriptor strobes
// address hold under back-pressure, strobes only inside a scan

`timescale 1ns/10ps

module obj_engine_assert (
    input logic        clk,
    input logic        rst,
    input logic        vb,
    input logic        vram_cs,
    input logic [23:1] vram_addr,
    input logic        vram_ok,
    input logic        obj_valid,
    input logic        scan_done
);

    logic last_vb;
    // high from a vb fall until scan_done
    logic in_scan;
    // failed assertions, read by the testbench
    int   fail_count = 0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_vb <= 1'b0;
            in_scan <= 1'b0;
        end else begin
            last_vb <= vb;
            if (last_vb && !vb) begin
                in_scan <= 1'b1;
            end else if (scan_done) begin
                in_scan <= 1'b0;
            end
        end
    end

    // no acknowledge, no address step
    addr_hold: assert property (@(posedge clk) disable iff (rst)
        vram_cs && !vram_ok |=> $stable(vram_addr))
        else begin
            $error("video RAM address moved without an acknowledge");
            fail_count++;
        end

    valid_in_scan: assert property (@(posedge clk) disable iff (rst)
        obj_valid |-> in_scan)
        else begin
            $error("object strobe outside a scan");
            fail_count++;
        end

    // one pulse per scan, in_scan drops with it
    done_pulse: assert property (@(posedge clk) disable iff (rst)
        scan_done |-> in_scan ##1 !scan_done)
        else begin
            $error("scan_done outside a scan or longer than one cycle");
            fail_count++;
        end

endmodule

// strobes and bus pins all live at the top level
bind obj_engine_top obj_engine_assert assert0 (.*);

/* testbench/obj_engine_tb.sv */
// object engine testbench
// clock, reset, video RAM model with random acknowledge delay
// per-frame stimulus read from obj_stimulus.txt
// descriptor checker against the previous frame's table, timeout

`timescale 1ns/10ps

module obj_engine_tb import obj_pkg::*;;

    localparam int max_frames   = 32;
    localparam int blank_cycles = 24;

    logic        clk;
    logic        rst;
    logic        vb;
    logic [15:0] vram_base;
    logic        vram_cs;
    logic [23:1] vram_addr;
    obj_word_t   vram_data;
    logic        vram_ok;
    logic        obj_valid;
    obj_word_t   obj_x;
    obj_word_t   obj_y;
    obj_word_t   obj_code;
    obj_word_t   obj_attr;
    logic        scan_done;

    // 64 tables of 1024 words indexed by base bits 8 to 3 and table index
    obj_word_t   vram_mem [0:65535];
    // base, end-marker entry, max delay per frame
    logic [15:0] stim [0:3*max_frames-1];
    obj_word_t   cur_img [0:obj_table_words-1];
    obj_word_t   prev_img [0:obj_table_words-1];
    int          delay_tab [0:obj_table_words-1];
    int          cur_count = 0;
    int          prev_count = 0;
    int          n_frames;
    int          frame_idx = 0;
    int          max_delay_all;
    int          obj_count = 0;
    int          done_count = 0;
    int          entry_word;
    int          word_cnt = 0;
    int          wait_left = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          error_count = 0;
    bit          scan_seen;
    bit          copy_done;
    bit          prev_cs;
    logic [15:0] copy_base;
    logic [23:1] cur_addr;
    logic [23:1] exp_addr;

    obj_engine_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Result: FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("FAIL time=%0t %s expected %h actual %h", $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic verify_outputs_idle();
        check_value("vram_cs", 0, vram_cs);
        check_value("obj_valid", 0, obj_valid);
        check_value("scan_done", 0, scan_done);
    endtask

    // word address {base[15:3], index} folded onto the 64K model
    function automatic int ram_index(input logic [15:0] base, input int index);
        return {base[8:3], index[9:0]};
    endfunction

    // places the end marker, snapshots the table, draws ok delays
    task automatic prepare_frame(input logic [15:0] base, input int marker,
                                 input int max_delay);
        int        i;
        int        idx;
        obj_word_t w;
        copy_base = base;
        for (i = 0; i < obj_table_words; i++) begin
            idx = ram_index(base, i);
            w = vram_mem[idx];
            // attribute word of entry i/4
            if (i % obj_words_per_entry == obj_words_per_entry - 1) begin
                if (i / obj_words_per_entry == marker) begin
                    w[15:8] = obj_end_attr;
                end else if (w[15:8] == obj_end_attr) begin
                    w[15:8] = w[15:8] ^ 8'h80;
                end
            end
            vram_mem[idx] = w;
            cur_img[i] = w;
            delay_tab[i] = $urandom_range(max_delay, 0);
        end
        cur_count = (marker < obj_max_entries) ? marker : obj_max_entries;
    endtask

    // video RAM model with a drawn ok delay per word
    always @(negedge clk) begin
        if (rst) begin
            prev_cs = 1'b0;
            vram_ok <= 1'b0;
        end else begin
            if (vram_cs && !prev_cs) begin
                word_cnt = 0;
            end
            if (vram_cs && (!prev_cs || vram_addr != cur_addr)) begin
                // next word of the copy on the bus
                exp_addr = {copy_base[15:3], word_cnt[9:0]};
                check_value("vram_addr", exp_addr, vram_addr);
                cur_addr = vram_addr;
                wait_left = delay_tab[word_cnt % obj_table_words];
                word_cnt++;
            end
            if (prev_cs && !vram_cs) begin
                check_value("copied words", obj_table_words, word_cnt);
                copy_done = 1'b1;
            end
            if (vram_cs && wait_left == 0) begin
                vram_ok <= 1'b1;
                vram_data <= vram_mem[vram_addr[16:1]];
            end else begin
                vram_ok <= 1'b0;
                if (vram_cs) begin
                    wait_left--;
                end
            end
            prev_cs = vram_cs;
        end
    end

    // descriptors against the table copied one frame earlier
    always @(negedge clk) begin
        if (!rst && obj_valid) begin
            if (frame_idx > 0) begin
                if (obj_count >= prev_count) begin
                    $display("scan emitted more objects than the table holds before its marker");
                    stop_with_failure();
                end else begin
                    entry_word = obj_count * obj_words_per_entry;
                    check_value("obj_x", prev_img[entry_word], obj_x);
                    check_value("obj_y", prev_img[entry_word + 1], obj_y);
                    check_value("obj_code", prev_img[entry_word + 2], obj_code);
                    check_value("obj_attr", prev_img[entry_word + 3], obj_attr);
                end
            end
            obj_count++;
        end
        if (!rst && scan_done) begin
            done_count++;
            scan_seen = 1'b1;
        end
    end

    // bound assertion failures end the run at the next falling edge
    always @(negedge clk) begin
        if (dut0.assert0.fail_count != 0) begin
            $display("a bound assertion on the video RAM bus or the strobes failed");
            stop_with_failure();
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout, the run went past %0d clock cycles", cycle_limit);
            stop_with_failure();
        end
    end

    initial begin
        int f;
        int i;
        void'($urandom(32'h2d6e_5f23));
        rst       = 1'b1;
        vb        = 1'b1;
        vram_base = 16'h0000;
        vram_data = 16'h0000;
        vram_ok   = 1'b0;
        for (i = 0; i < 65536; i++) begin
            vram_mem[i] = $urandom;
        end
        $readmemh("testbench/obj_stimulus.txt", stim);
        n_frames = 0;
        max_delay_all = 0;
        while (n_frames < max_frames && !$isunknown(stim[3*n_frames])) begin
            if (stim[3*n_frames + 2] > max_delay_all) begin
                max_delay_all = stim[3*n_frames + 2];
            end
            n_frames++;
        end
        if (n_frames < 2) begin
            $display("stimulus file holds fewer than two frames");
            stop_with_failure();
        end
        // copy and scan bounded per frame plus reset and idle margin
        cycle_limit = n_frames * (obj_table_words * (max_delay_all + 2) + 2100
                      + blank_cycles) + 100;

        repeat (5) begin
            @(negedge clk);
            verify_outputs_idle();
        end
        rst = 1'b0;
        // quiet until the first vb fall
        repeat (8) begin
            @(negedge clk);
            verify_outputs_idle();
        end

        for (f = 0; f < n_frames; f++) begin
            for (i = 0; i < obj_table_words; i++) begin
                prev_img[i] = cur_img[i];
            end
            prev_count = cur_count;
            frame_idx  = f;
            obj_count  = 0;
            done_count = 0;
            scan_seen  = 1'b0;
            copy_done  = 1'b0;
            vram_base  = stim[3*f];
            prepare_frame(stim[3*f], stim[3*f + 1], stim[3*f + 2]);
            vb = 1'b0;
            while (!vram_cs) begin
                @(negedge clk);
            end
            // new base mid-copy takes effect on the next frame
            vram_base = (f + 1 < n_frames) ? stim[3*f + 3] : ~stim[3*f];
            while (!(scan_seen && copy_done)) begin
                @(negedge clk);
            end
            vb = 1'b1;
            repeat (blank_cycles) @(negedge clk);
            check_value("scan_done pulses", 1, done_count);
            if (f > 0) begin
                check_value("object count", prev_count, obj_count);
            end
        end

        check_value("assertion failures", 0, dut0.assert0.fail_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

/* testbench/obj_stimulus.txt */
// columns, all hex: table base, end-marker entry (100 = no marker), max ok delay
// one frame per line, the first frame's scan output is not checked
0000 100 0
0a17 040 3
0a17 0ff 1
1238 000 2
0010 100 5
0010 001 0
7fff 080 4
00c8 0fe 6
4103 100 1
4103 002 2
01f8 07f 0
8008 100 3
8008 010 5
0020 0c0 2
3e40 100 0
3e40 003 6
0100 100 4
0108 0aa 1
0108 000 0
fff8 055 3
0a10 100 2
0a10 0f0 5
2222 011 1
0058 100 6
0058 020 0
1180 100 2

/* sources.f */
common/obj_pkg.sv
common/obj_vram_if.sv
obj/obj_table.sv
obj/obj_scan.sv
rtl/obj_engine_top.sv
testbench/obj_engine_assert.sv
testbench/obj_engine_tb.sv
